// ==== logic/ioport_pkg.sv ====
// ioport package
// bus widths, port counts, command opcodes and the auto-clear
// settings shared by the byte-wide I/O port block
`default_nettype none

package ioport_pkg;

    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int NUM_OUT_PORTS  = 4;
    localparam int NUM_IN_PORTS   = 4;

    typedef logic [BYTE_W-1:0]                byte_t;  // one host bus byte
    typedef logic [BYTES_PER_WORD*BYTE_W-1:0] word_t;  // one port word

    typedef logic [$clog2(NUM_OUT_PORTS)-1:0] out_sel_t;
    typedef logic [$clog2(NUM_IN_PORTS)-1:0]  in_sel_t;

    // command field, bits 6:4 of a command byte
    typedef enum logic [2:0] {
        OP_CLEAR = 3'd1,
        OP_WRITE = 3'd2,
        OP_READ  = 3'd3
    } opcode_t;

    // this output port returns to zero on its own after a write
    localparam out_sel_t AUTO_CLEAR_PORT   = out_sel_t'(3);
    localparam int       AUTO_CLEAR_CYCLES = 4;  // cycles from visible write to zero

endpackage

`default_nettype wire

// ==== logic/port_cmd_if.sv ====
// port command interface
// carries one decoded host command from the decoder to the port bank
// as a single-cycle strobe with its operands
`timescale 1ns/1ps
`default_nettype none

interface port_cmd_if;
    import ioport_pkg::*;

    logic        cmd_valid;  // one-cycle strobe, no back-pressure
    opcode_t     cmd_op;
    logic [3:0]  cmd_port;   // port field of the command byte
    word_t       cmd_word;   // write data, meaningful for OP_WRITE

    modport decoder (
        output cmd_valid,
        output cmd_op,
        output cmd_port,
        output cmd_word
    );

    modport bank (
        input  cmd_valid,
        input  cmd_op,
        input  cmd_port,
        input  cmd_word
    );

endinterface

`default_nettype wire

// ==== logic/read_word_if.sv ====
// read word interface
// hands a captured input word to the byte sender, busy flag flows back
`timescale 1ns/1ps
`default_nettype none

interface read_word_if;
    import ioport_pkg::*;

    logic  rd_valid;  // one-cycle strobe
    word_t rd_word;
    logic  busy;      // high while the word goes out

    modport bank (
        output rd_valid,
        output rd_word
    );

    modport sender (
        input  rd_valid,
        input  rd_word,
        output busy
    );

endinterface

`default_nettype wire

// ==== logic/cmd_decoder.sv ====
// command decoder
// takes host bytes marked by load, decodes the opcode field and
// assembles the four data bytes of a write, msb first
// host bytes are dropped while a read is being sent back
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  ioport_pkg::byte_t data_in,
    port_cmd_if.decoder       cmd,
    read_word_if.sender       rd
);
    import ioport_pkg::*;

    localparam int CNT_W = $clog2(BYTES_PER_WORD);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_DATA,  // collecting write bytes
        ST_RD_WAIT   // read issued, sender not busy yet
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    logic             accept;

    assign accept = load && !rd.busy;  // no commands while a read is out

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= ST_IDLE;
            byte_cnt      <= '0;
            cmd.cmd_valid <= 1'b0;
        end
        else
        begin
            cmd.cmd_valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        case (data_in[6:4])
                            OP_CLEAR: cmd.cmd_valid <= 1'b1;
                            OP_WRITE: state <= ST_WR_DATA;
                            OP_READ:
                            begin
                                cmd.cmd_valid <= 1'b1;
                                state         <= ST_RD_WAIT;
                            end
                            default: ;  // unknown opcode, dropped
                        endcase
                    end
                end
                ST_WR_DATA:
                begin
                    if (load)
                    begin
                        if (byte_cnt == CNT_W'(BYTES_PER_WORD - 1))
                        begin
                            cmd.cmd_valid <= 1'b1;  // word complete
                            byte_cnt      <= '0;
                            state         <= ST_IDLE;
                        end
                        else
                            byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                ST_RD_WAIT:
                begin
                    if (rd.busy)
                        state <= ST_IDLE;  // busy now guards the decoder
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operands, only looked at while cmd_valid is high
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && accept)
        begin
            cmd.cmd_op   <= opcode_t'(data_in[6:4]);
            cmd.cmd_port <= data_in[3:0];
        end
        if (state == ST_WR_DATA && load)
            cmd.cmd_word <= {cmd.cmd_word[$bits(word_t)-BYTE_W-1:0], data_in};  // msb first
    end

endmodule

`default_nettype wire

// ==== logic/port_bank.sv ====
// port bank
// holds the output port registers, applies clear and write commands,
// zeroes the auto-clear port after a fixed delay and captures the
// selected input word for a read
`timescale 1ns/1ps
`default_nettype none

module port_bank (
    input  logic              clk,
    input  logic              reset,
    input  ioport_pkg::word_t in0,
    input  ioport_pkg::word_t in1,
    input  ioport_pkg::word_t in2,
    input  ioport_pkg::word_t in3,
    output ioport_pkg::word_t out0,
    output ioport_pkg::word_t out1,
    output ioport_pkg::word_t out2,
    output ioport_pkg::word_t out3,
    port_cmd_if.bank          cmd,
    read_word_if.bank         rd
);
    import ioport_pkg::*;

    localparam int CNT_W = $clog2(AUTO_CLEAR_CYCLES + 1);

    word_t            out_q    [NUM_OUT_PORTS];
    word_t            in_words [NUM_IN_PORTS];
    out_sel_t         wr_sel;
    in_sel_t          rd_sel;
    logic [CNT_W-1:0] clr_cnt;  // 0 means no clear pending

    assign in_words[0] = in0;
    assign in_words[1] = in1;
    assign in_words[2] = in2;
    assign in_words[3] = in3;

    assign wr_sel = cmd.cmd_port[$bits(out_sel_t)-1:0];
    assign rd_sel = cmd.cmd_port[$bits(in_sel_t)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_OUT_PORTS; i++)
                out_q[i] <= '0;
            clr_cnt     <= '0;
            rd.rd_valid <= 1'b0;
        end
        else
        begin
            rd.rd_valid <= 1'b0;
            if (clr_cnt != '0)
            begin
                clr_cnt <= clr_cnt - 1'b1;
                if (clr_cnt == CNT_W'(1))
                    out_q[AUTO_CLEAR_PORT] <= '0;  // delay expired
            end
            // a command in the same cycle takes priority over the countdown
            if (cmd.cmd_valid)
            begin
                case (cmd.cmd_op)
                    OP_CLEAR:
                    begin
                        for (int i = 0; i < NUM_OUT_PORTS; i++)
                            out_q[i] <= '0;
                        clr_cnt <= '0;
                    end
                    OP_WRITE:
                    begin
                        out_q[wr_sel] <= cmd.cmd_word;
                        if (wr_sel == AUTO_CLEAR_PORT)
                            clr_cnt <= CNT_W'(AUTO_CLEAR_CYCLES);  // restart count
                    end
                    OP_READ: rd.rd_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // input sampled on the strobe cycle
    always_ff @(posedge clk)
    begin
        if (cmd.cmd_valid && cmd.cmd_op == OP_READ)
            rd.rd_word <= in_words[rd_sel];
    end

    assign out0 = out_q[0];
    assign out1 = out_q[1];
    assign out2 = out_q[2];
    assign out3 = out_q[3];

endmodule

`default_nettype wire

// ==== logic/byte_sender.sv ====
// byte sender
// sends a captured word back to the host one byte at a time, msb first
// each byte: en_out rises after ready is seen high and drops one cycle
// after ready goes low, then the next ready is awaited
`timescale 1ns/1ps
`default_nettype none

module byte_sender (
    input  logic               clk,
    input  logic               reset,
    input  logic               ready,
    output ioport_pkg::byte_t  data_out,
    output logic               en_out,
    read_word_if.sender        rd
);
    import ioport_pkg::*;

    localparam int CNT_W = $clog2(BYTES_PER_WORD);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_RDY,  // waiting for ready high
        ST_HOLD       // en_out up, waiting for ready low
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    word_t            word_q;  // remaining bytes, next one on top

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            en_out   <= 1'b0;
            rd.busy  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (rd.rd_valid)
                    begin
                        rd.busy  <= 1'b1;
                        byte_cnt <= '0;
                        state    <= ST_WAIT_RDY;
                    end
                end
                ST_WAIT_RDY:
                begin
                    if (ready)
                    begin
                        en_out <= 1'b1;
                        state  <= ST_HOLD;
                    end
                end
                ST_HOLD:
                begin
                    if (!ready)
                    begin
                        en_out <= 1'b0;
                        if (byte_cnt == CNT_W'(BYTES_PER_WORD - 1))
                        begin
                            rd.busy <= 1'b0;  // last byte released
                            state   <= ST_IDLE;
                        end
                        else
                        begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= ST_WAIT_RDY;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && rd.rd_valid)
            word_q <= rd.rd_word;
        else if (state == ST_WAIT_RDY && ready)
        begin
            data_out <= word_q[$bits(word_t)-1 -: BYTE_W];  // top byte out
            word_q   <= word_q << BYTE_W;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ioports_top.sv ====
// I/O ports top level
// byte-wide command port with four output and four input word ports
// decoder feeds the port bank, the bank feeds the byte sender
`timescale 1ns/1ps
`default_nettype none

module ioports_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  ioport_pkg::byte_t data_in,
    input  logic              ready,
    input  ioport_pkg::word_t in0,
    input  ioport_pkg::word_t in1,
    input  ioport_pkg::word_t in2,
    input  ioport_pkg::word_t in3,
    output ioport_pkg::byte_t data_out,
    output logic              en_out,
    output ioport_pkg::word_t out0,
    output ioport_pkg::word_t out1,
    output ioport_pkg::word_t out2,
    output ioport_pkg::word_t out3
);

    port_cmd_if  cmd_bus ();
    read_word_if rd_bus ();

    cmd_decoder u_cmd_decoder (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .data_in (data_in),
        .cmd     (cmd_bus.decoder),
        .rd      (rd_bus.sender)    // busy only
    );

    port_bank u_port_bank (
        .clk   (clk),
        .reset (reset),
        .in0   (in0),
        .in1   (in1),
        .in2   (in2),
        .in3   (in3),
        .out0  (out0),
        .out1  (out1),
        .out2  (out2),
        .out3  (out3),
        .cmd   (cmd_bus.bank),
        .rd    (rd_bus.bank)
    );

    byte_sender u_byte_sender (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .data_out (data_out),
        .en_out   (en_out),
        .rd       (rd_bus.sender)
    );

endmodule

`default_nettype wire

// ==== dv/ioports_assertions.sv ====
// I/O ports assertions
// handshake rules on ready/en_out and single-cycle internal strobes,
// bound into the top level
`timescale 1ns/1ps
`default_nettype none

module ioports_assertions (
    input logic              clk,
    input logic              reset,
    input logic              ready,
    input logic              en_out,
    input ioport_pkg::byte_t data_out,
    input logic              cmd_valid,
    input logic              rd_valid
);

    int fail_count = 0;  // read by the testbench at the end

    en_rise_after_ready: assert property (@(posedge clk) disable iff (reset)
        $rose(en_out) |-> $past(ready))
    else
    begin
        fail_count++;
        $error("en_out rose while ready was low");
    end

    data_stable_while_en: assert property (@(posedge clk) disable iff (reset)
        (en_out && $past(en_out)) |-> $stable(data_out))
    else
    begin
        fail_count++;
        $error("data_out changed while en_out was high");
    end

    cmd_valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |=> !cmd_valid)
    else
    begin
        fail_count++;
        $error("cmd_valid high for two cycles");
    end

    rd_valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rd_valid |=> !rd_valid)
    else
    begin
        fail_count++;
        $error("rd_valid high for two cycles");
    end

endmodule

`default_nettype wire

// ==== dv/ioports_tb.sv ====
// I/O ports testbench
// directed tests for port writes, auto-clear, clear, reads through a
// host model on ready/en_out, ignored bytes during a read and unknown opcodes
`timescale 1ns/1ps
`default_nettype none

module ioports_tb;
    import ioport_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RUN_CYCLES    = 5000;  // well above the few hundred cycles of the tests
    localparam int WATCHDOG_NS   = RUN_CYCLES * CLK_PERIOD_NS;
    localparam int WAIT_LIMIT    = 50;    // cycles to wait for en_out

    logic        clk;
    logic        reset;
    logic        load;
    byte_t       data_in;
    logic        ready;
    word_t       in0;
    word_t       in1;
    word_t       in2;
    word_t       in3;
    byte_t       data_out;
    logic        en_out;
    word_t       out0;
    word_t       out1;
    word_t       out2;
    word_t       out3;

    word_t       exp_out [NUM_OUT_PORTS];
    word_t       in_val  [NUM_IN_PORTS];
    logic [31:0] rng;
    int          errors   = 0;
    int          en_rises = 0;
    logic        en_seen  = 1'b0;

    ioports_top u_ioports_top (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .data_in  (data_in),
        .ready    (ready),
        .in0      (in0),
        .in1      (in1),
        .in2      (in2),
        .in3      (in3),
        .data_out (data_out),
        .en_out   (en_out),
        .out0     (out0),
        .out1     (out1),
        .out2     (out2),
        .out3     (out3)
    );

    bind ioports_top ioports_assertions u_assertions (
        .clk       (clk),
        .reset     (reset),
        .ready     (ready),
        .en_out    (en_out),
        .data_out  (data_out),
        .cmd_valid (cmd_bus.cmd_valid),
        .rd_valid  (rd_bus.rd_valid)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    always @(negedge clk)  // count bytes released to the host
    begin
        if (en_out && !en_seen)
            en_rises = en_rises + 1;
        en_seen = en_out;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic byte_t make_command(input logic [2:0] op, input int port);
        return {1'b0, op, 4'(port)};  // bit 7 unused
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic check_outputs();
        check_word("out0", exp_out[0], out0);
        check_word("out1", exp_out[1], out1);
        check_word("out2", exp_out[2], out2);
        check_word("out3", exp_out[3], out3);
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge clk);
        load    <= 1'b1;
        data_in <= b;
        @(posedge clk);
        load    <= 1'b0;
    endtask

    task automatic write_port(input int port, input word_t w);
        send_byte(make_command(OP_WRITE, port));
        for (int i = BYTES_PER_WORD - 1; i >= 0; i--)
            send_byte(w[8*i +: 8]);  // msb first
        exp_out[port] = w;
        @(posedge clk);  // register updates after the cmd_valid cycle
        @(negedge clk);
        check_outputs();
    endtask

    task automatic clear_ports();
        send_byte(make_command(OP_CLEAR, 0));
        for (int i = 0; i < NUM_OUT_PORTS; i++)
            exp_out[i] = '0;
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    // host side of one byte with ready raised, held and then dropped
    task automatic host_ready(input int hold, output byte_t b);
        int waited;
        @(posedge clk);
        ready <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!en_out && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!en_out)
            report_failure("en_out did not rise while ready was high");
        b = data_out;
        repeat (hold) @(negedge clk);
        @(posedge clk);
        ready <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (en_out && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (en_out)
            report_failure("en_out did not drop after ready went low");
    endtask

    task automatic read_port(input int idx, input int hold, input int delay, input bit inject);
        word_t got;
        byte_t b;
        int    rises_before;
        got = '0;
        send_byte(make_command(OP_READ, idx));
        rises_before = en_rises;
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
            host_ready(hold, b);
            got = {got[23:0], b};
            if (inject && i == 0)
            begin
                send_byte(make_command(OP_CLEAR, 0));  // all of these must be dropped
                send_byte(make_command(OP_WRITE, 1));
                for (int k = 0; k < BYTES_PER_WORD; k++)
                    send_byte(8'h5a);
            end
            repeat (delay) @(posedge clk);
        end
        @(posedge clk);
        if (en_rises - rises_before != BYTES_PER_WORD)
            report_failure($sformatf("read of in%0d released %0d bytes instead of 4",
                                     idx, en_rises - rises_before));
        check_word($sformatf("read word of in%0d", idx), in_val[idx], got);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic new_inputs();
        @(posedge clk);
        for (int i = 0; i < NUM_IN_PORTS; i++)
            in_val[i] = next_rand();
        in0 <= in_val[0];
        in1 <= in_val[1];
        in2 <= in_val[2];
        in3 <= in_val[3];
    endtask

    task automatic auto_clear_port3();
        word_t w;
        int    waited;
        w = next_rand() | 32'h1;  // never zero
        write_port(AUTO_CLEAR_PORT, w);
        waited = 0;
        while (out3 !== '0 && waited < 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (out3 !== '0)
            report_failure("out3 did not return to zero within 8 cycles");
        exp_out[AUTO_CLEAR_PORT] = '0;
        check_outputs();
    endtask

    task automatic unknown_opcode();
        int rises_before;
        send_byte(make_command(3'd7, 2));
        rises_before = en_rises;
        ready <= 1'b1;  // a started read would answer this
        repeat (8) @(posedge clk);
        ready <= 1'b0;
        @(posedge clk);
        if (en_rises != rises_before)
            report_failure("unknown opcode started a read");
        @(negedge clk);
        check_outputs();
    endtask

    initial
    begin
        int total;
        clk     = 1'b0;
        reset   = 1'b1;
        load    = 1'b0;
        data_in = '0;
        ready   = 1'b0;
        rng     = 32'h2909ced7;
        for (int i = 0; i < NUM_IN_PORTS; i++)
        begin
            in_val[i]  = next_rand();
            exp_out[i] = '0;
        end
        in0 = in_val[0];
        in1 = in_val[1];
        in2 = in_val[2];
        in3 = in_val[3];
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_outputs();

        for (int p = 0; p < 3; p++)
            write_port(p, next_rand());
        auto_clear_port3();
        unknown_opcode();
        read_port(2, 5, 6, 1'b1);  // long and late ready with injected bytes
        new_inputs();
        for (int i = 0; i < NUM_IN_PORTS; i++)
            read_port(i, 0, 0, 1'b0);
        write_port(AUTO_CLEAR_PORT, next_rand() | 32'h1);  // clear lands before the countdown
        clear_ports();

        @(posedge clk);
        total = errors + u_ioports_top.u_assertions.fail_count;
        $display("Error count: %0d (%0d from checks, %0d from assertions)",
                 total, errors, u_ioports_top.u_assertions.fail_count);
        if (total == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns, the run did not finish", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/ioport_pkg.sv
logic/port_cmd_if.sv
logic/read_word_if.sv
logic/cmd_decoder.sv
logic/port_bank.sv
logic/byte_sender.sv
logic/ioports_top.sv
dv/ioports_assertions.sv
dv/ioports_tb.sv

// ==== Bender.yml ====
package:
  name: ioports

sources:
  - logic/ioport_pkg.sv
  - logic/port_cmd_if.sv
  - logic/read_word_if.sv
  - logic/cmd_decoder.sv
  - logic/port_bank.sv
  - logic/byte_sender.sv
  - logic/ioports_top.sv
  - target: simulation
    files:
      - dv/ioports_assertions.sv
      - dv/ioports_tb.sv
